/* list.f */
+incdir+src
src/i2c_wbs_pkg.sv
src/i2c_byte_fifo.sv
src/i2c_sticky_flags.sv
src/i2c_wbs_regs.sv
src/i2c_master_wbs.sv
verif/i2c_master_wbs_checker.sv
verif/tb_clk_gen.sv
verif/tb_i2c_master_wbs.sv

/* verif/tb_i2c_master_wbs.sv */
/*
 * Testbench top for the Wishbone I2C front end
 * Wishbone host tasks, engine stream model with expected queues,
 * xorshift data, register, stream, overflow and status tests, watchdog
 */
`timescale 1ns/1ps
`include "i2c_wbs_config.svh"

module tb_i2c_master_wbs;

  localparam int ACK_TIMEOUT = 16;
  localparam int DRAIN_TIMEOUT = 64;
  // Rough length of all tests, watchdog allows four times that
  localparam int TEST_CYCLES = 5000;
  localparam int WATCHDOG_CYCLES = 4 * TEST_CYCLES;
  localparam logic [15:0] DEF_PRESCALE = `I2C_WBS_DEFAULT_PRESCALE;

  logic                        clk;
  logic                        rst;
  logic [`I2C_WBS_ADDR_W-1:0]  wb_adr;
  logic [7:0]                  wb_dat_w;
  logic [7:0]                  wb_dat_r;
  logic                        wb_we;
  logic                        wb_stb;
  logic                        wb_ack;
  logic                        wb_cyc;
  i2c_wbs_pkg::i2c_cmd_t       cmd;
  logic                        cmd_valid;
  logic                        cmd_ready;
  logic [7:0]                  wr_data;
  logic                        wr_valid;
  logic                        wr_ready;
  logic [7:0]                  rd_data;
  logic                        rd_valid;
  logic                        rd_ready;
  i2c_wbs_pkg::bus_status_t    bus_status;
  logic [15:0]                 prescale;
  int                          errors;
  logic [31:0]                 rng_state;
  i2c_wbs_pkg::i2c_cmd_t       exp_cmds[$];
  logic [7:0]                  exp_wr[$];
  logic [7:0]                  exp_rd[$];

  tb_clk_gen u_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  i2c_master_wbs u_dut (
    .clk          (clk),
    .rst          (rst),
    .wb_adr_i     (wb_adr),
    .wb_dat_i     (wb_dat_w),
    .wb_dat_o     (wb_dat_r),
    .wb_we_i      (wb_we),
    .wb_stb_i     (wb_stb),
    .wb_ack_o     (wb_ack),
    .wb_cyc_i     (wb_cyc),
    .cmd_o        (cmd),
    .cmd_valid_o  (cmd_valid),
    .cmd_ready_i  (cmd_ready),
    .wr_data_o    (wr_data),
    .wr_valid_o   (wr_valid),
    .wr_ready_i   (wr_ready),
    .rd_data_i    (rd_data),
    .rd_valid_i   (rd_valid),
    .rd_ready_o   (rd_ready),
    .bus_status_i (bus_status),
    .prescale_o   (prescale)
  );

  bind i2c_master_wbs i2c_master_wbs_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_ack_i    (wb_ack_o),
    .cmd_i       (cmd_o),
    .cmd_valid_i (cmd_valid_o),
    .cmd_ready_i (cmd_ready_i),
    .wr_data_i   (wr_data_o),
    .wr_valid_i  (wr_valid_o),
    .wr_ready_i  (wr_ready_i)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [7:0] random_byte();
    rng_state = xorshift32(rng_state);
    return rng_state[7:0];
  endfunction

  // Command as the engine should see it
  function automatic i2c_wbs_pkg::i2c_cmd_t make_cmd(input logic [6:0] addr,
                                                     input logic [7:0] flags);
    i2c_wbs_pkg::i2c_cmd_t c;
    c.addr  = addr;
    c.start = flags[0];
    c.read  = flags[1];
    c.write = flags[2];
    c.stop  = flags[4];
    return c;
  endfunction

  // FIFO status byte from occupancy and overflow state
  function automatic logic [7:0] fifo_status_value(input int cmd_n, input logic cmd_ovf,
                                                   input int wr_n, input logic wr_ovf,
                                                   input int rd_n);
    logic [7:0] v;
    v[0] = (cmd_n == 0);
    v[1] = (cmd_n == `I2C_WBS_CMD_DEPTH);
    v[2] = cmd_ovf;
    v[3] = (wr_n == 0);
    v[4] = (wr_n == `I2C_WBS_WR_DEPTH);
    v[5] = wr_ovf;
    v[6] = (rd_n == 0);
    v[7] = (rd_n == `I2C_WBS_RD_DEPTH);
    return v;
  endfunction

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    assert (actual === expected) else begin
      $display("[ERROR] %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // One classic cycle, strobe dropped once the ack is seen
  task automatic bus_access(input logic we, input i2c_wbs_pkg::reg_addr_e addr,
                            input logic [7:0] wdata, output logic [7:0] rdata);
    int n;
    @(negedge clk);
    wb_adr   = addr;
    wb_dat_w = wdata;
    wb_we    = we;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!wb_ack && n < ACK_TIMEOUT);
    if (!wb_ack) begin
      $display("Wishbone access to register %0d was never acknowledged", addr);
      errors++;
    end
    rdata  = wb_dat_r;
    wb_stb = 1'b0;
    wb_cyc = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_write(input i2c_wbs_pkg::reg_addr_e addr, input logic [7:0] data);
    logic [7:0] unused;
    bus_access(1'b1, addr, data, unused);
  endtask

  task automatic expect_read(input string name, input i2c_wbs_pkg::reg_addr_e addr,
                             input logic [7:0] expected);
    logic [7:0] data;
    bus_access(1'b0, addr, 8'h00, data);
    check_value(name, expected, data);
  endtask

  // Command write, expected on the stream when a flag is set and room is left
  task automatic send_cmd(input logic [6:0] addr, input logic [7:0] flags,
                          input logic delivered);
    if (delivered && (flags & 8'h17) != 0) begin
      exp_cmds.push_back(make_cmd(addr, flags));
    end
    bus_write(i2c_wbs_pkg::REG_CMD, flags);
  endtask

  task automatic wait_for_drain(input string name);
    int n;
    n = 0;
    while ((exp_cmds.size() != 0 || exp_wr.size() != 0) && n < DRAIN_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (exp_cmds.size() != 0 || exp_wr.size() != 0) begin
      $display("%s: the engine side never received all expected words", name);
      errors++;
    end
  endtask

  // Engine pushes one read byte once there is room
  task automatic push_read_byte(input logic [7:0] data);
    @(negedge clk);
    while (!rd_ready) begin
      @(negedge clk);
    end
    rd_data  = data;
    rd_valid = 1'b1;
    @(negedge clk);
    rd_valid = 1'b0;
  endtask

  // Engine side monitor, compares in arrival order
  always @(posedge clk) begin
    if (!rst && cmd_valid && cmd_ready) begin
      if (exp_cmds.size() == 0) begin
        $display("Command stream delivered a command that was not expected");
        errors++;
      end else begin
        check_value("cmd_stream", exp_cmds.pop_front(), cmd);
      end
    end
    if (!rst && wr_valid && wr_ready) begin
      if (exp_wr.size() == 0) begin
        $display("Write stream delivered a byte that was not expected");
        errors++;
      end else begin
        check_value("wr_stream", exp_wr.pop_front(), wr_data);
      end
    end
  end

  task automatic test_registers();
    logic [7:0] lo;
    logic [7:0] hi;
    expect_read("prescale_lo_reset", i2c_wbs_pkg::REG_PRESCALE_LO, DEF_PRESCALE[7:0]);
    expect_read("prescale_hi_reset", i2c_wbs_pkg::REG_PRESCALE_HI, DEF_PRESCALE[15:8]);
    bus_write(i2c_wbs_pkg::REG_CMD_ADDR, 8'h5a);
    expect_read("cmd_addr", i2c_wbs_pkg::REG_CMD_ADDR, 8'h5a);
    lo = random_byte();
    hi = random_byte();
    bus_write(i2c_wbs_pkg::REG_PRESCALE_LO, lo);
    bus_write(i2c_wbs_pkg::REG_PRESCALE_HI, hi);
    expect_read("prescale_lo", i2c_wbs_pkg::REG_PRESCALE_LO, lo);
    expect_read("prescale_hi", i2c_wbs_pkg::REG_PRESCALE_HI, hi);
    check_value("prescale_port", {hi, lo}, prescale);
    expect_read("reserved", i2c_wbs_pkg::REG_RESERVED, 8'h00);
  endtask

  task automatic test_commands();
    logic [7:0] flags;
    @(negedge clk);
    cmd_ready = 1'b1;
    bus_write(i2c_wbs_pkg::REG_CMD_ADDR, 8'h21);
    for (int i = 0; i < 3; i++) begin
      flags = random_byte() & 8'h17;
      send_cmd(7'h21, (flags == 8'h00) ? 8'h01 : flags, 1'b1);
    end
    bus_write(i2c_wbs_pkg::REG_CMD_ADDR, 8'h4c);
    // Only bit 3, which is no flag, so nothing may appear before the next one
    send_cmd(7'h4c, 8'h08, 1'b1);
    send_cmd(7'h4c, 8'h13, 1'b1);
    wait_for_drain("commands");
    // Same flow with the engine stalled, the fifth command is lost
    @(negedge clk);
    cmd_ready = 1'b0;
    for (int i = 0; i <= `I2C_WBS_CMD_DEPTH; i++) begin
      send_cmd(7'h4c, 8'h01 << (i % 3), i < `I2C_WBS_CMD_DEPTH);
    end
    check_value("cmd_head_held", exp_cmds[0], cmd);
    expect_read("cmd_overflow", i2c_wbs_pkg::REG_FIFO_STATUS,
                fifo_status_value(`I2C_WBS_CMD_DEPTH, 1'b1, 0, 1'b0, 0));
    bus_write(i2c_wbs_pkg::REG_FIFO_STATUS, 8'h04);
    expect_read("cmd_ovf_clear", i2c_wbs_pkg::REG_FIFO_STATUS,
                fifo_status_value(`I2C_WBS_CMD_DEPTH, 1'b0, 0, 1'b0, 0));
    @(negedge clk);
    cmd_ready = 1'b1;
    wait_for_drain("command backlog");
  endtask

  task automatic test_write_data();
    logic [7:0] b;
    @(negedge clk);
    wr_ready = 1'b1;
    for (int i = 0; i < 6; i++) begin
      b = random_byte();
      exp_wr.push_back(b);
      bus_write(i2c_wbs_pkg::REG_DATA, b);
    end
    wait_for_drain("write bytes");
    @(negedge clk);
    wr_ready = 1'b0;
    for (int i = 0; i <= `I2C_WBS_WR_DEPTH; i++) begin
      b = random_byte();
      if (i < `I2C_WBS_WR_DEPTH) begin
        exp_wr.push_back(b);
      end
      bus_write(i2c_wbs_pkg::REG_DATA, b);
    end
    check_value("wr_head_held", exp_wr[0], wr_data);
    expect_read("wr_overflow", i2c_wbs_pkg::REG_FIFO_STATUS,
                fifo_status_value(0, 1'b0, `I2C_WBS_WR_DEPTH, 1'b1, 0));
    bus_write(i2c_wbs_pkg::REG_FIFO_STATUS, 8'h20);
    expect_read("wr_ovf_clear", i2c_wbs_pkg::REG_FIFO_STATUS,
                fifo_status_value(0, 1'b0, `I2C_WBS_WR_DEPTH, 1'b0, 0));
    @(negedge clk);
    wr_ready = 1'b1;
    wait_for_drain("write backlog");
    // Lost byte must not show up
    expect_read("wr_drained", i2c_wbs_pkg::REG_FIFO_STATUS,
                fifo_status_value(0, 1'b0, 0, 1'b0, 0));
  endtask

  task automatic test_read_data();
    logic [7:0] b;
    for (int i = 0; i < `I2C_WBS_RD_DEPTH; i++) begin
      b = random_byte();
      exp_rd.push_back(b);
      push_read_byte(b);
    end
    expect_read("rd_full", i2c_wbs_pkg::REG_FIFO_STATUS,
                fifo_status_value(0, 1'b0, 0, 1'b0, `I2C_WBS_RD_DEPTH));
    // No room left for the engine
    check_value("rd_ready_full", 1'b0, rd_ready);
    for (int i = 0; i < `I2C_WBS_RD_DEPTH; i++) begin
      expect_read("rd_data", i2c_wbs_pkg::REG_DATA, exp_rd.pop_front());
      expect_read("rd_count", i2c_wbs_pkg::REG_FIFO_STATUS,
                  fifo_status_value(0, 1'b0, 0, 1'b0, `I2C_WBS_RD_DEPTH - 1 - i));
    end
    check_value("rd_ready_room", 1'b1, rd_ready);
    // Empty FIFO reads zero and pops nothing
    expect_read("rd_empty_data", i2c_wbs_pkg::REG_DATA, 8'h00);
    expect_read("rd_empty_data", i2c_wbs_pkg::REG_DATA, 8'h00);
  endtask

  task automatic test_status();
    @(negedge clk);
    bus_status.busy        = 1'b1;
    bus_status.bus_control = 1'b0;
    bus_status.bus_active  = 1'b1;
    expect_read("status_bits", i2c_wbs_pkg::REG_STATUS, 8'h05);
    // One-cycle missed ack pulse from the engine
    @(negedge clk);
    bus_status.missed_ack = 1'b1;
    @(negedge clk);
    bus_status.missed_ack  = 1'b0;
    bus_status.busy        = 1'b0;
    bus_status.bus_control = 1'b1;
    bus_status.bus_active  = 1'b0;
    expect_read("missed_ack_sticky", i2c_wbs_pkg::REG_STATUS, 8'h0a);
    expect_read("missed_ack_held", i2c_wbs_pkg::REG_STATUS, 8'h0a);
    bus_write(i2c_wbs_pkg::REG_STATUS, 8'h08);
    expect_read("missed_ack_clear", i2c_wbs_pkg::REG_STATUS, 8'h02);
  endtask

  initial begin
    wb_adr     = '0;
    wb_dat_w   = '0;
    wb_we      = 1'b0;
    wb_stb     = 1'b0;
    wb_cyc     = 1'b0;
    cmd_ready  = 1'b0;
    wr_ready   = 1'b0;
    rd_data    = '0;
    rd_valid   = 1'b0;
    bus_status = '0;
    errors     = 0;
    rng_state  = 32'hc377_7a0a;
    wait (!rst);
    test_registers();
    test_commands();
    test_write_data();
    test_read_data();
    test_status();
    repeat (2) @(negedge clk);
    $display("Errors: %0d value checks, %0d protocol assertions",
             errors, u_dut.u_checker.fail_count);
    if (errors == 0 && u_dut.u_checker.fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Hang guard
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* verif/tb_clk_gen.sv */
/*
 * Testbench clock and reset source
 * 10 ns clock, reset held high for 5 cycles
 */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_PERIOD = 5,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Release on a falling edge, like every other DUT input
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

/* verif/i2c_master_wbs_checker.sv */
/*
 * Protocol assertions bound into the I2C front end top level
 * Wishbone ack timing, stream valid after reset, stream stability
 */
`timescale 1ns/1ps

module i2c_master_wbs_checker (
  input logic                  clk,
  input logic                  rst,
  input logic                  wb_cyc_i,
  input logic                  wb_stb_i,
  input logic                  wb_ack_i,
  input i2c_wbs_pkg::i2c_cmd_t cmd_i,
  input logic                  cmd_valid_i,
  input logic                  cmd_ready_i,
  input logic [7:0]            wr_data_i,
  input logic                  wr_valid_i,
  input logic                  wr_ready_i
);

  // Failures seen so far, read by the testbench top
  int fail_count;

  initial fail_count = 0;

  // New strobe gets its ack on the next edge
  ack_after_strobe: assert property (@(posedge clk) disable iff (rst)
    (wb_cyc_i && wb_stb_i && !wb_ack_i) |=> wb_ack_i)
    else begin
      $error("Wishbone ack missing one cycle after a new strobe");
      fail_count++;
    end

  // Single-cycle ack
  ack_single: assert property (@(posedge clk) disable iff (rst)
    wb_ack_i |=> !wb_ack_i)
    else begin
      $error("Wishbone ack high for two cycles in a row");
      fail_count++;
    end

  // Covers every reset cycle and the first one after it
  valid_low_in_reset: assert property (@(posedge clk)
    rst |=> (!cmd_valid_i && !wr_valid_i))
    else begin
      $error("Stream valid high during or right after reset");
      fail_count++;
    end

  // Head held under back-pressure
  cmd_stable: assert property (@(posedge clk) disable iff (rst)
    (cmd_valid_i && !cmd_ready_i) |=> (cmd_valid_i && $stable(cmd_i)))
    else begin
      $error("Command changed while waiting for ready");
      fail_count++;
    end

  wr_stable: assert property (@(posedge clk) disable iff (rst)
    (wr_valid_i && !wr_ready_i) |=> (wr_valid_i && $stable(wr_data_i)))
    else begin
      $error("Write byte changed while waiting for ready");
      fail_count++;
    end

endmodule

/* src/i2c_master_wbs.sv */
/*
 * Top level of the Wishbone I2C front end
 * Register block, command, write and read FIFOs, sticky flags,
 * engine-side valid/ready streams and status inputs
 */
`timescale 1ns/1ps
`include "i2c_wbs_config.svh"

module i2c_master_wbs (
  input  logic                           clk,
  input  logic                           rst,
  // Wishbone slave
  input  logic [`I2C_WBS_ADDR_W-1:0]     wb_adr_i,
  input  logic [`I2C_WBS_DATA_W-1:0]     wb_dat_i,
  output logic [`I2C_WBS_DATA_W-1:0]     wb_dat_o,
  input  logic                           wb_we_i,
  input  logic                           wb_stb_i,
  output logic                           wb_ack_o,
  input  logic                           wb_cyc_i,
  // Command stream
  output i2c_wbs_pkg::i2c_cmd_t          cmd_o,
  output logic                           cmd_valid_o,
  input  logic                           cmd_ready_i,
  // Write byte stream
  output logic [`I2C_WBS_DATA_W-1:0]     wr_data_o,
  output logic                           wr_valid_o,
  input  logic                           wr_ready_i,
  // Read byte stream
  input  logic [`I2C_WBS_DATA_W-1:0]     rd_data_i,
  input  logic                           rd_valid_i,
  output logic                           rd_ready_o,
  // Engine status and config
  input  i2c_wbs_pkg::bus_status_t       bus_status_i,
  output logic [`I2C_WBS_PRESCALE_W-1:0] prescale_o
);

  i2c_wbs_pkg::i2c_cmd_t         cmd_in;
  i2c_wbs_pkg::fifo_status_t     fifo_status;
  i2c_wbs_pkg::sticky_flags_t    flags;
  logic                          cmd_push;
  logic                          wr_push;
  logic                          rd_pop;
  logic [`I2C_WBS_DATA_W-1:0]    wr_byte;
  logic [`I2C_WBS_DATA_W-1:0]    rd_head;
  logic                          clr_missed_ack;
  logic                          clr_cmd_ovf;
  logic                          clr_wr_ovf;

  // Status register image
  assign fifo_status.cmd_ovf = flags.cmd_ovf;
  assign fifo_status.wr_ovf  = flags.wr_ovf;

  i2c_wbs_regs u_regs (
    .clk              (clk),
    .rst              (rst),
    .wb_adr_i         (i2c_wbs_pkg::reg_addr_e'(wb_adr_i)),
    .wb_dat_i         (wb_dat_i),
    .wb_dat_o         (wb_dat_o),
    .wb_we_i          (wb_we_i),
    .wb_stb_i         (wb_stb_i),
    .wb_ack_o         (wb_ack_o),
    .wb_cyc_i         (wb_cyc_i),
    .fifo_status_i    (fifo_status),
    .rd_head_i        (rd_head),
    .bus_status_i     (bus_status_i),
    .missed_ack_i     (flags.missed_ack),
    .cmd_push_o       (cmd_push),
    .cmd_o            (cmd_in),
    .wr_push_o        (wr_push),
    .wr_data_o        (wr_byte),
    .rd_pop_o         (rd_pop),
    .prescale_o       (prescale_o),
    .clr_missed_ack_o (clr_missed_ack),
    .clr_cmd_ovf_o    (clr_cmd_ovf),
    .clr_wr_ovf_o     (clr_wr_ovf)
  );

  // Host to engine commands
  i2c_byte_fifo #(
    .WIDTH ($bits(i2c_wbs_pkg::i2c_cmd_t)),
    .DEPTH (`I2C_WBS_CMD_DEPTH)
  ) u_cmd_fifo (
    .clk         (clk),
    .rst         (rst),
    .in_data_i   (cmd_in),
    .in_valid_i  (cmd_push),
    .in_ready_o  (),
    .out_data_o  (cmd_o),
    .out_valid_o (cmd_valid_o),
    .out_ready_i (cmd_ready_i),
    .full_o      (fifo_status.cmd_full),
    .empty_o     (fifo_status.cmd_empty)
  );

  // Host to engine write bytes
  i2c_byte_fifo #(
    .WIDTH (`I2C_WBS_DATA_W),
    .DEPTH (`I2C_WBS_WR_DEPTH)
  ) u_wr_fifo (
    .clk         (clk),
    .rst         (rst),
    .in_data_i   (wr_byte),
    .in_valid_i  (wr_push),
    .in_ready_o  (),
    .out_data_o  (wr_data_o),
    .out_valid_o (wr_valid_o),
    .out_ready_i (wr_ready_i),
    .full_o      (fifo_status.wr_full),
    .empty_o     (fifo_status.wr_empty)
  );

  // Engine to host read bytes
  // Engine sees ready whenever there is room
  i2c_byte_fifo #(
    .WIDTH (`I2C_WBS_DATA_W),
    .DEPTH (`I2C_WBS_RD_DEPTH)
  ) u_rd_fifo (
    .clk         (clk),
    .rst         (rst),
    .in_data_i   (rd_data_i),
    .in_valid_i  (rd_valid_i),
    .in_ready_o  (rd_ready_o),
    .out_data_o  (rd_head),
    .out_valid_o (),
    .out_ready_i (rd_pop),
    .full_o      (fifo_status.rd_full),
    .empty_o     (fifo_status.rd_empty)
  );

  i2c_sticky_flags u_flags (
    .clk                (clk),
    .rst                (rst),
    .missed_ack_pulse_i (bus_status_i.missed_ack),
    .cmd_push_i         (cmd_push),
    .cmd_full_i         (fifo_status.cmd_full),
    .wr_push_i          (wr_push),
    .wr_full_i          (fifo_status.wr_full),
    .clr_missed_ack_i   (clr_missed_ack),
    .clr_cmd_ovf_i      (clr_cmd_ovf),
    .clr_wr_ovf_i       (clr_wr_ovf),
    .flags_o            (flags)
  );

endmodule

/* src/i2c_wbs_regs.sv */
/*
 * Wishbone register block for the I2C front end
 * Cycle decode and ack, command address and prescale registers,
 * command build, registered readback, FIFO push and pop strobes,
 * write-1-to-clear pulses for the sticky flags
 */
`timescale 1ns/1ps
`include "i2c_wbs_config.svh"

module i2c_wbs_regs (
  input  logic                               clk,
  input  logic                               rst,
  // Wishbone slave
  input  i2c_wbs_pkg::reg_addr_e             wb_adr_i,
  input  logic [`I2C_WBS_DATA_W-1:0]         wb_dat_i,
  output logic [`I2C_WBS_DATA_W-1:0]         wb_dat_o,
  input  logic                               wb_we_i,
  input  logic                               wb_stb_i,
  output logic                               wb_ack_o,
  input  logic                               wb_cyc_i,
  // Status in
  input  i2c_wbs_pkg::fifo_status_t          fifo_status_i,
  input  logic [`I2C_WBS_DATA_W-1:0]         rd_head_i,
  input  i2c_wbs_pkg::bus_status_t           bus_status_i,
  input  logic                               missed_ack_i,
  // FIFO control
  output logic                               cmd_push_o,
  output i2c_wbs_pkg::i2c_cmd_t              cmd_o,
  output logic                               wr_push_o,
  output logic [`I2C_WBS_DATA_W-1:0]         wr_data_o,
  output logic                               rd_pop_o,
  // Engine config
  output logic [`I2C_WBS_PRESCALE_W-1:0]     prescale_o,
  // Flag clears
  output logic                               clr_missed_ack_o,
  output logic                               clr_cmd_ovf_o,
  output logic                               clr_wr_ovf_o
);

  logic [`I2C_WBS_DEV_ADDR_W-1:0] cmd_addr_q;
  logic                           wb_req;
  logic                           wb_wr;
  logic                           wb_rd;
  logic                           sel_status;
  logic                           sel_fifo;
  logic                           sel_cmd;
  logic                           sel_data;
  logic                           cmd_any;

  // New transfer only while the ack is low
  // All side effects hang off this term
  assign wb_req = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wb_wr  = wb_req & wb_we_i;
  assign wb_rd  = wb_req & ~wb_we_i;

  // Address decode for registers with side effects
  assign sel_status = (wb_adr_i == i2c_wbs_pkg::REG_STATUS);
  assign sel_fifo   = (wb_adr_i == i2c_wbs_pkg::REG_FIFO_STATUS);
  assign sel_cmd    = (wb_adr_i == i2c_wbs_pkg::REG_CMD);
  assign sel_data   = (wb_adr_i == i2c_wbs_pkg::REG_DATA);

  // Start, read, write or stop requested
  // Bit 3 is not a flag
  assign cmd_any = wb_dat_i[0] | wb_dat_i[1] | wb_dat_i[2] | wb_dat_i[4];

  // Control registers
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack_o         <= 1'b0;
      cmd_push_o       <= 1'b0;
      wr_push_o        <= 1'b0;
      rd_pop_o         <= 1'b0;
      clr_missed_ack_o <= 1'b0;
      clr_cmd_ovf_o    <= 1'b0;
      clr_wr_ovf_o     <= 1'b0;
      cmd_addr_q       <= '0;
      cmd_o            <= '0;
      prescale_o       <= `I2C_WBS_PRESCALE_W'(`I2C_WBS_DEFAULT_PRESCALE);
    end else begin
      // Ack one cycle after the strobe, never twice in a row
      wb_ack_o <= wb_cyc_i & wb_stb_i & ~wb_ack_o;

      // One-cycle strobes toward the FIFOs
      // Full check happens in the flag block
      cmd_push_o <= wb_wr & sel_cmd & cmd_any;
      wr_push_o  <= wb_wr & sel_data;
      // Empty read pops nothing
      rd_pop_o   <= wb_rd & sel_data & ~fifo_status_i.rd_empty;

      // Write 1 to clear
      clr_missed_ack_o <= wb_wr & sel_status & wb_dat_i[3];
      clr_cmd_ovf_o    <= wb_wr & sel_fifo & wb_dat_i[2];
      clr_wr_ovf_o     <= wb_wr & sel_fifo & wb_dat_i[5];

      if (wb_wr) begin
        case (wb_adr_i)
          i2c_wbs_pkg::REG_CMD_ADDR: begin
            cmd_addr_q <= wb_dat_i[`I2C_WBS_DEV_ADDR_W-1:0];
          end
          i2c_wbs_pkg::REG_CMD: begin
            // Held address is captured with the flags
            cmd_o.addr  <= cmd_addr_q;
            cmd_o.start <= wb_dat_i[0];
            cmd_o.read  <= wb_dat_i[1];
            cmd_o.write <= wb_dat_i[2];
            cmd_o.stop  <= wb_dat_i[4];
          end
          i2c_wbs_pkg::REG_PRESCALE_LO: begin
            prescale_o[`I2C_WBS_DATA_W-1:0] <= wb_dat_i;
          end
          i2c_wbs_pkg::REG_PRESCALE_HI: begin
            prescale_o[`I2C_WBS_PRESCALE_W-1:`I2C_WBS_DATA_W] <= wb_dat_i;
          end
          default: begin
            // Status, FIFO status and data handled above
            cmd_addr_q <= cmd_addr_q;
          end
        endcase
      end
    end
  end

  // Write byte, valid one cycle later from wr_push_o
  always_ff @(posedge clk) begin
    if (wb_wr && sel_data) begin
      wr_data_o <= wb_dat_i;
    end
  end

  // Readback mux, lands with the ack
  always_ff @(posedge clk) begin
    wb_dat_o <= '0;
    if (wb_rd) begin
      case (wb_adr_i)
        i2c_wbs_pkg::REG_STATUS: begin
          wb_dat_o <= {4'b0000, missed_ack_i, bus_status_i.bus_active,
                       bus_status_i.bus_control, bus_status_i.busy};
        end
        i2c_wbs_pkg::REG_FIFO_STATUS: begin
          wb_dat_o <= fifo_status_i;
        end
        i2c_wbs_pkg::REG_CMD_ADDR: begin
          wb_dat_o <= {{(`I2C_WBS_DATA_W - `I2C_WBS_DEV_ADDR_W){1'b0}}, cmd_addr_q};
        end
        i2c_wbs_pkg::REG_CMD: begin
          // Bit 3 reads as 0
          wb_dat_o <= {3'b000, cmd_o.stop, 1'b0, cmd_o.write, cmd_o.read, cmd_o.start};
        end
        i2c_wbs_pkg::REG_DATA: begin
          wb_dat_o <= fifo_status_i.rd_empty ? '0 : rd_head_i;
        end
        i2c_wbs_pkg::REG_PRESCALE_LO: begin
          wb_dat_o <= prescale_o[`I2C_WBS_DATA_W-1:0];
        end
        i2c_wbs_pkg::REG_PRESCALE_HI: begin
          wb_dat_o <= prescale_o[`I2C_WBS_PRESCALE_W-1:`I2C_WBS_DATA_W];
        end
        default: begin
          // Reserved reads zero
          wb_dat_o <= '0;
        end
      endcase
    end
  end

endmodule

/* src/i2c_sticky_flags.sv */
/*
 * Sticky status bits for the I2C front end
 * Missed ack, command FIFO overflow, write FIFO overflow,
 * each cleared by a write-1-to-clear pulse
 */
`timescale 1ns/1ps

module i2c_sticky_flags (
  input  logic                       clk,
  input  logic                       rst,
  // Set sources
  input  logic                       missed_ack_pulse_i,
  input  logic                       cmd_push_i,
  input  logic                       cmd_full_i,
  input  logic                       wr_push_i,
  input  logic                       wr_full_i,
  // Clear pulses from the register block
  input  logic                       clr_missed_ack_i,
  input  logic                       clr_cmd_ovf_i,
  input  logic                       clr_wr_ovf_i,
  output i2c_wbs_pkg::sticky_flags_t flags_o
);

  logic cmd_ovf_set;
  logic wr_ovf_set;

  // Push meets a full FIFO, so the word is lost
  assign cmd_ovf_set = cmd_push_i & cmd_full_i;
  assign wr_ovf_set  = wr_push_i & wr_full_i;

  // Set in the same cycle as a clear keeps the flag
  always_ff @(posedge clk) begin
    if (rst) begin
      flags_o <= '0;
    end else begin
      flags_o.missed_ack <= missed_ack_pulse_i |
                            (flags_o.missed_ack & ~clr_missed_ack_i);
      flags_o.cmd_ovf    <= cmd_ovf_set | (flags_o.cmd_ovf & ~clr_cmd_ovf_i);
      flags_o.wr_ovf     <= wr_ovf_set | (flags_o.wr_ovf & ~clr_wr_ovf_i);
    end
  end

endmodule

/* src/i2c_byte_fifo.sv */
/*
 * Synchronous first-word-fall-through FIFO
 * Valid/ready on both sides, full and empty flags,
 * any width and any depth of 2 or more
 */
`timescale 1ns/1ps

module i2c_byte_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             rst,
  // Write side
  input  logic [WIDTH-1:0] in_data_i,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  // Read side, head word shown without a pop
  output logic [WIDTH-1:0] out_data_o,
  output logic             out_valid_o,
  input  logic             out_ready_i,
  // Occupancy
  output logic             full_o,
  output logic             empty_o
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Flags straight from the registered count
  assign full_o      = (count == CNT_W'(DEPTH));
  assign empty_o     = (count == '0);
  assign in_ready_o  = ~full_o;
  assign out_valid_o = ~empty_o;
  assign out_data_o  = mem[rd_ptr];

  // Push into a full FIFO is dropped here
  assign do_push = in_valid_i & ~full_o;
  assign do_pop  = out_ready_i & ~empty_o;

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= in_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap at DEPTH, so non power of 2 depths work
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop keeps the count
      case ({do_push, do_pop})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

endmodule

/* src/i2c_wbs_pkg.sv */
/*
 * Shared types for the Wishbone I2C front end
 * Register address map, engine command, FIFO status,
 * engine bus status and sticky flag bundle
 */
`include "i2c_wbs_config.svh"

package i2c_wbs_pkg;

  // Host register map
  typedef enum logic [`I2C_WBS_ADDR_W-1:0] {
    REG_STATUS      = 3'd0,
    REG_FIFO_STATUS = 3'd1,
    REG_CMD_ADDR    = 3'd2,
    REG_CMD         = 3'd3,
    REG_DATA        = 3'd4,
    REG_RESERVED    = 3'd5,
    REG_PRESCALE_LO = 3'd6,
    REG_PRESCALE_HI = 3'd7
  } reg_addr_e;

  // One engine command
  // Flags may be combined, engine orders them start, read or write, stop
  typedef struct packed {
    logic [`I2C_WBS_DEV_ADDR_W-1:0] addr;
    logic                           start;
    logic                           read;
    logic                           write;
    logic                           stop;
  } i2c_cmd_t;

  // FIFO status register layout, bit 0 is cmd_empty
  typedef struct packed {
    logic rd_full;
    logic rd_empty;
    logic wr_ovf;
    logic wr_full;
    logic wr_empty;
    logic cmd_ovf;
    logic cmd_full;
    logic cmd_empty;
  } fifo_status_t;

  // Engine status, bit 0 is busy
  // missed_ack only strobes for one cycle
  typedef struct packed {
    logic missed_ack;
    logic bus_active;
    logic bus_control;
    logic busy;
  } bus_status_t;

  // Write-1-to-clear flags held by the flag block
  typedef struct packed {
    logic wr_ovf;
    logic cmd_ovf;
    logic missed_ack;
  } sticky_flags_t;

endpackage

/* src/i2c_wbs_config.svh */
/*
 * Build-time constants for the Wishbone I2C front end
 * Data and address widths, prescale width and reset value, FIFO depths
 */
`ifndef I2C_WBS_CONFIG_SVH
`define I2C_WBS_CONFIG_SVH

// Wishbone data bus and byte stream width
`define I2C_WBS_DATA_W 8
// Register address bits on the host port
`define I2C_WBS_ADDR_W 3
// 7-bit I2C device address
`define I2C_WBS_DEV_ADDR_W 7

// Bit engine prescale register
`define I2C_WBS_PRESCALE_W 16
`define I2C_WBS_DEFAULT_PRESCALE 1

// Small depths so the full state is easy to reach
`define I2C_WBS_CMD_DEPTH 4
`define I2C_WBS_WR_DEPTH 4
`define I2C_WBS_RD_DEPTH 4

`endif
